//--- logic/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int ALEN = 32;
    localparam int ILEN = 32;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct7 of the base encoding and of the SUB/SRA variant
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [ILEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_cond_t;

    typedef enum logic [2:0] {
        ST_CLEAR, ST_FETCH, ST_WAIT, ST_EXECUTE, ST_WRITEBACK
    } core_state_t;

endpackage

//--- logic/decoded_if.sv
`timescale 1ns/1ps

// Decoded fields of the instruction currently held by the decoder
interface decoded_if import core_pkg::*; ();

    logic [4:0]      rs1_sel;
    logic [4:0]      rs2_sel;
    logic [4:0]      rd_sel;
    logic [XLEN-1:0] imm;
    alu_op_t         alu_op;
    branch_cond_t    branch_cond;
    logic            use_imm;
    logic            use_pc;
    logic            is_jump;
    logic            is_jalr;
    logic            reg_write;
    logic            illegal;

    modport source (
        output rs1_sel, rs2_sel, rd_sel, imm, alu_op, branch_cond,
        output use_imm, use_pc, is_jump, is_jalr, reg_write, illegal
    );

    modport sink (
        input rs1_sel, rs2_sel, rd_sel, imm, alu_op, branch_cond,
        input use_imm, use_pc, is_jump, is_jalr, reg_write, illegal
    );

endinterface

//--- logic/reg_clear_counter.sv
`timescale 1ns/1ps

module reg_clear_counter (
    input  logic       clk,
    input  logic       rst,
    output logic [4:0] clear_sel,
    output logic       clearing
);

    // Walks x31 down to x1, one register per cycle, then stops
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_sel <= 5'd31;
            clearing  <= 1'b1;
        end else if (clearing) begin
            clear_sel <= clear_sel - 5'd1;
            // x1 is written in this cycle, so the sweep is complete
            if (clear_sel == 5'd1) begin
                clearing <= 1'b0;
            end
        end
    end

endmodule

//--- logic/core_control.sv
`timescale 1ns/1ps

module core_control import core_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          clearing,
    input  logic          imem_valid,
    decoded_if.sink       dec,
    output logic          imem_req,
    output logic          capture,
    output logic          exec_en,
    output logic          reg_write_en,
    output logic          pc_update,
    output logic          retire,
    output logic          illegal
);

    core_state_t state;
    core_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_CLEAR;
        end else begin
            state <= state_next;
        end
    end

    // One instruction in flight; only the wait for the fetch has a variable length
    always_comb begin
        state_next = state;
        case (state)
            ST_CLEAR: begin
                if (!clearing) begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH: state_next = ST_WAIT;
            ST_WAIT: begin
                if (imem_valid) begin
                    state_next = ST_EXECUTE;
                end
            end
            ST_EXECUTE:   state_next = ST_WRITEBACK;
            ST_WRITEBACK: state_next = ST_FETCH;
            default:      state_next = ST_CLEAR;
        endcase
    end

    assign imem_req = (state == ST_FETCH);
    assign capture  = (state == ST_WAIT) && imem_valid;
    assign exec_en  = (state == ST_EXECUTE);

    // Everything that commits the instruction happens in the writeback cycle
    assign pc_update    = (state == ST_WRITEBACK);
    assign retire       = (state == ST_WRITEBACK);
    assign illegal      = (state == ST_WRITEBACK) && dec.illegal;
    assign reg_write_en = (state == ST_WRITEBACK) && dec.reg_write && (dec.rd_sel != 5'd0);

endmodule

//--- logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            capture,
    input  logic [ILEN-1:0] imem_rdata,
    decoded_if.source       dec,
    output logic [ILEN-1:0] instr
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // funct3 selects the operation for both OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_t alu_op_from_funct(input logic [2:0] f3, input logic alt,
                                                  input logic reg_op);
        case (f3)
            F3_ADD_SUB: return (alt && reg_op) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    // Starts out holding a NOP so the decode outputs are defined before the first fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= NOP_INSTR;
        end else if (capture) begin
            instr <= imem_rdata;
        end
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign dec.rs1_sel = instr[19:15];
    assign dec.rs2_sel = instr[24:20];
    assign dec.rd_sel  = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.imm         = imm_i;
        dec.alu_op      = ALU_ADD;
        dec.branch_cond = BR_NONE;
        dec.use_imm     = 1'b0;
        dec.use_pc      = 1'b0;
        dec.is_jump     = 1'b0;
        dec.is_jalr     = 1'b0;
        dec.reg_write   = 1'b0;
        dec.illegal     = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.alu_op    = alu_op_from_funct(funct3, funct7 == F7_ALT, 1'b1);
                dec.reg_write = 1'b1;
                // Only ADD/SUB and SRL/SRA have an alternate encoding
                if (funct7 != F7_BASE && !(funct7 == F7_ALT &&
                        (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA))) begin
                    dec.reg_write = 1'b0;
                    dec.illegal   = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec.alu_op    = alu_op_from_funct(funct3, funct7 == F7_ALT, 1'b0);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec.branch_cond = BR_EQ;
                    F3_BNE:  dec.branch_cond = BR_NE;
                    F3_BLT:  dec.branch_cond = BR_LT;
                    F3_BGE:  dec.branch_cond = BR_GE;
                    F3_BLTU: dec.branch_cond = BR_LTU;
                    F3_BGEU: dec.branch_cond = BR_GEU;
                    default: dec.illegal     = 1'b1;
                endcase
            end
            OPC_JAL: begin
                // The ALU adds PC and offset to form the target
                dec.imm       = imm_j;
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.is_jump   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_JALR: begin
                dec.use_imm   = 1'b1;
                dec.is_jump   = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    decoded_if.sink         dec,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [ALEN-1:0] pc,
    output logic [XLEN-1:0] result,
    output logic [ALEN-1:0] next_pc
);

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;
    logic            branch_taken;
    logic [ALEN-1:0] link_addr;
    logic [ALEN-1:0] branch_target;
    logic [ALEN-1:0] jump_target;

    assign operand_a = dec.use_pc ? pc : rs1_data;
    assign operand_b = dec.use_imm ? dec.imm : rs2_data;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_out = operand_a + operand_b;
            ALU_SUB:  alu_out = operand_a - operand_b;
            ALU_AND:  alu_out = operand_a & operand_b;
            ALU_OR:   alu_out = operand_a | operand_b;
            ALU_XOR:  alu_out = operand_a ^ operand_b;
            ALU_SLT:  alu_out = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: alu_out = {31'b0, operand_a < operand_b};
            ALU_SLL:  alu_out = operand_a << shamt;
            ALU_SRL:  alu_out = operand_a >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(operand_a) >>> shamt);
            default:  alu_out = operand_b;
        endcase
    end

    // Branches compare the two source registers, independent of the ALU operands
    always_comb begin
        case (dec.branch_cond)
            BR_EQ:   branch_taken = (rs1_data == rs2_data);
            BR_NE:   branch_taken = (rs1_data != rs2_data);
            BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  branch_taken = (rs1_data < rs2_data);
            BR_GEU:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    assign link_addr     = pc + 32'd4;
    assign branch_target = pc + dec.imm;
    assign jump_target   = dec.is_jalr ? {alu_out[ALEN-1:1], 1'b0} : alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            result  <= '0;
            next_pc <= '0;
        end else if (exec_en) begin
            result  <= dec.is_jump ? link_addr : alu_out;
            if (dec.is_jump) begin
                next_pc <= jump_target;
            end else begin
                next_pc <= branch_taken ? branch_target : link_addr;
            end
        end
    end

endmodule

//--- logic/int_regfile.sv
`timescale 1ns/1ps

module int_regfile import core_pkg::*; (
    input  logic            clk,
    input  logic            write_en,
    input  logic [4:0]      write_sel,
    input  logic [XLEN-1:0] write_data,
    input  logic [4:0]      read1_sel,
    input  logic [4:0]      read2_sel,
    input  logic [4:0]      read3_sel,
    output logic [XLEN-1:0] read1_data,
    output logic [XLEN-1:0] read2_data,
    output logic [XLEN-1:0] read3_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (write_en && write_sel != 5'd0) begin
            regs[write_sel] <= write_data;
        end
    end

    // x0 is hardwired to zero, entry 0 of the array is never read
    assign read1_data = (read1_sel == 5'd0) ? '0 : regs[read1_sel];
    assign read2_data = (read2_sel == 5'd0) ? '0 : regs[read2_sel];
    assign read3_data = (read3_sel == 5'd0) ? '0 : regs[read3_sel];

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import core_pkg::*; #(
    parameter logic [ALEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pc_update,
    input  logic [ALEN-1:0] next_pc,
    output logic [ALEN-1:0] pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= next_pc;
        end
    end

endmodule

//--- logic/core.sv
`timescale 1ns/1ps

module core import core_pkg::*; #(
    parameter logic [ALEN-1:0] RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 imem_req,
    output logic [ALEN-1:0]      imem_addr,
    input  logic                 imem_valid,
    input  logic [ILEN-1:0]      imem_rdata,
    input  logic [4:0]           reg_read_sel,
    output logic [XLEN-1:0]      reg_read_data,
    output logic [ALEN-1:0]      reg_pc,
    output logic [ALEN+ILEN-1:0] fetch_instr,
    output logic                 retire,
    output logic                 illegal
);

    logic [4:0]      clear_sel;
    logic            clearing;
    logic            capture;
    logic            exec_en;
    logic            reg_write_en;
    logic            pc_update;
    logic [ILEN-1:0] instr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] result;
    logic [ALEN-1:0] next_pc;
    logic [ALEN-1:0] pc;

    decoded_if dec ();

    reg_clear_counter u_clear (.clk, .rst, .clear_sel, .clearing);

    core_control u_control (
        .clk, .rst, .clearing, .imem_valid, .dec(dec),
        .imem_req, .capture, .exec_en, .reg_write_en, .pc_update, .retire, .illegal
    );

    instr_decode u_decode (.clk, .rst, .capture, .imem_rdata, .dec(dec), .instr);

    alu u_alu (
        .clk, .rst, .exec_en, .dec(dec),
        .rs1_data, .rs2_data, .pc, .result, .next_pc
    );

    // The clear sweep owns the write port until it finishes
    int_regfile u_regs (
        .clk,
        .write_en   (clearing | reg_write_en),
        .write_sel  (clearing ? clear_sel : dec.rd_sel),
        .write_data (clearing ? '0 : result),
        .read1_sel  (dec.rs1_sel),
        .read2_sel  (dec.rs2_sel),
        .read3_sel  (reg_read_sel),
        .read1_data (rs1_data),
        .read2_data (rs2_data),
        .read3_data (reg_read_data)
    );

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (.clk, .rst, .pc_update, .next_pc, .pc);

    assign imem_addr   = pc;
    assign reg_pc      = pc;
    // PC only moves at the end of writeback, so it still names the retiring instruction
    assign fetch_instr = {pc, instr};

endmodule

//--- verification/core_checker.sv
`timescale 1ns/1ps

module core_checker #(
    parameter int ROWS = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_req,
    input  logic [31:0] imem_addr,
    input  logic        imem_valid,
    input  logic [31:0] reg_read_data,
    input  logic [31:0] reg_pc,
    input  logic [63:0] fetch_instr,
    input  logic        retire,
    input  logic        illegal,
    input  logic        sweep_active,
    input  logic [4:0]  reg_read_sel,
    input  logic [63:0] exp_name,
    input  logic [31:0] exp_instr,
    input  logic [31:0] exp_addr,
    input  logic [31:0] exp_value,
    input  logic [31:0] exp_next_pc,
    input  logic        exp_illegal,
    output int          error_count,
    output int          retire_count,
    output int          sweep_count,
    output logic        done
);

    int          cycle;
    int          valid_cycle;
    int          retire_cycle;
    logic        valid_open;
    logic        seen_req;
    logic        post_check;
    logic [63:0] name_q;
    logic [31:0] value_q;
    logic [31:0] next_pc_q;

    task automatic report_value(input logic [63:0] tag, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %0s %0s: expected %h, actual %h", tag, what, expected, actual);
    endtask

    task automatic report_fault(input string msg);
        error_count++;
        $display("Error at cycle %0d: %0s", cycle, msg);
    endtask

    // Sampled mid-cycle, when all DUT outputs have settled
    always @(negedge clk) begin
        if (rst) begin
            error_count  = 0;
            retire_count = 0;
            sweep_count  = 0;
            done         = 1'b0;
            cycle        = 0;
            valid_open   = 1'b0;
            seen_req     = 1'b0;
            post_check   = 1'b0;
        end else begin
            cycle++;
            if (sweep_active) begin
                sweep_count++;
                if (reg_read_data !== 32'd0) begin
                    report_value("reset", $sformatf("x%0d", reg_read_sel), 32'd0, reg_read_data);
                end
            end
            if (imem_req) begin
                if (!seen_req) begin
                    seen_req = 1'b1;
                    if (imem_addr !== 32'd0) begin
                        report_value("first_fetch", "imem_addr", 32'd0, imem_addr);
                    end
                end else if (cycle != retire_cycle + 1) begin
                    report_fault("imem_req did not follow retire by one cycle");
                end
            end
            if (imem_valid) begin
                valid_open  = 1'b1;
                valid_cycle = cycle;
            end
            // Register write and PC update of the last retire are visible one cycle later
            if (post_check) begin
                post_check = 1'b0;
                if (reg_read_data !== value_q) begin
                    report_value(name_q, "register", value_q, reg_read_data);
                end
                if (reg_pc !== next_pc_q) begin
                    report_value(name_q, "next pc", next_pc_q, reg_pc);
                end
                if (retire_count == ROWS) begin
                    if (sweep_count != 32) begin
                        report_fault($sformatf("reset sweep read %0d registers", sweep_count));
                    end
                    done = 1'b1;
                end
            end
            if (retire) begin
                if (!valid_open || cycle != valid_cycle + 2) begin
                    report_fault("retire did not follow imem_valid by two cycles");
                end
                valid_open = 1'b0;
                if (fetch_instr[63:32] !== exp_addr) begin
                    report_value(exp_name, "fetch address", exp_addr, fetch_instr[63:32]);
                end
                if (fetch_instr[31:0] !== exp_instr) begin
                    report_value(exp_name, "instruction", exp_instr, fetch_instr[31:0]);
                end
                if (illegal !== exp_illegal) begin
                    report_value(exp_name, "illegal", {31'd0, exp_illegal}, {31'd0, illegal});
                end
                name_q       = exp_name;
                value_q      = exp_value;
                next_pc_q    = exp_next_pc;
                retire_count++;
                retire_cycle = cycle;
                post_check   = 1'b1;
            end else if (illegal) begin
                report_fault("illegal pulsed without retire");
            end
        end
    end

endmodule

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int ROWS = 38;
    // Worst row is fetch, wait of up to 6 cycles, execute and writeback
    localparam int TIMEOUT = ROWS * 12 + 40;

    localparam logic [6:0] OPI   = 7'h13;
    localparam logic [6:0] JALR  = 7'h67;
    localparam logic [6:0] ALT   = 7'h20;

    typedef struct packed {
        logic [63:0] name;
        logic [31:0] instr;
        logic [31:0] addr;
        logic [4:0]  sel;
        logic [31:0] value;
        logic [31:0] next_pc;
        logic        illegal;
    } row_t;

    row_t        prog [ROWS];
    row_t        cur;
    int          row_count;
    int          cycles;
    logic        clk;
    logic        rst;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic [4:0]  reg_read_sel;
    logic [31:0] reg_read_data;
    logic [31:0] reg_pc;
    logic [63:0] fetch_instr;
    logic        retire;
    logic        illegal;
    logic        sweep_active;
    int          error_count;
    int          retire_count;
    int          sweep_count;
    logic        done;

    core #(.RESET_PC(32'h0)) u_core (
        .clk, .rst, .imem_req, .imem_addr, .imem_valid, .imem_rdata,
        .reg_read_sel, .reg_read_data, .reg_pc, .fetch_instr, .retire, .illegal
    );

    core_checker #(.ROWS(ROWS)) u_checker (
        .clk, .rst, .imem_req, .imem_addr, .imem_valid, .reg_read_data, .reg_pc,
        .fetch_instr, .retire, .illegal, .sweep_active, .reg_read_sel,
        .exp_name(cur.name), .exp_instr(cur.instr), .exp_addr(cur.addr),
        .exp_value(cur.value), .exp_next_pc(cur.next_pc), .exp_illegal(cur.illegal),
        .error_count, .retire_count, .sweep_count, .done
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input logic [63:0] name, input logic [31:0] instr,
                           input logic [31:0] addr, input logic [4:0] sel,
                           input logic [31:0] value, input logic [31:0] next_pc,
                           input logic ill);
        prog[row_count] = '{name, instr, addr, sel, value, next_pc, ill};
        row_count++;
    endtask

    // x1 = 5 and x2 = -3 feed most of the rows below
    task automatic load_program();
        row_count = 0;
        add_row("addi",   i_type(OPI, 0, 1, 0, 12'd5),   0,  1,  32'd5,        4,  0);
        add_row("addi_n", i_type(OPI, 0, 2, 0, 12'hffd), 4,  2,  32'hfffffffd, 8,  0);
        add_row("add",    r_type(0, 0, 3, 1, 2),       8,  3,  32'd2,        12, 0);
        add_row("sub",    r_type(0, ALT, 4, 1, 2),     12, 4,  32'd8,        16, 0);
        add_row("and",    r_type(7, 0, 5, 1, 2),       16, 5,  32'd5,        20, 0);
        add_row("or",     r_type(6, 0, 6, 1, 2),       20, 6,  32'hfffffffd, 24, 0);
        add_row("xor",    r_type(4, 0, 7, 1, 2),       24, 7,  32'hfffffff8, 28, 0);
        add_row("slt",    r_type(2, 0, 8, 2, 1),       28, 8,  32'd1,        32, 0);
        add_row("sltu",   r_type(3, 0, 9, 2, 1),       32, 9,  32'd0,        36, 0);
        add_row("sll",    r_type(1, 0, 10, 1, 1),      36, 10, 32'ha0,       40, 0);
        add_row("srl",    r_type(5, 0, 11, 2, 1),      40, 11, 32'h07ffffff, 44, 0);
        add_row("sra",    r_type(5, ALT, 12, 2, 1),    44, 12, 32'hffffffff, 48, 0);
        add_row("slti",   i_type(OPI, 2, 13, 2, 12'hffe), 48, 13, 32'd1,        52, 0);
        add_row("sltiu",  i_type(OPI, 3, 14, 1, 12'hfff), 52, 14, 32'd1,        56, 0);
        add_row("andi",   i_type(OPI, 7, 15, 2, 12'h0f0), 56, 15, 32'hf0,       60, 0);
        add_row("ori",    i_type(OPI, 6, 16, 1, 12'h700), 60, 16, 32'h705,      64, 0);
        add_row("xori",   i_type(OPI, 4, 17, 2, 12'hfff), 64, 17, 32'd2,        68, 0);
        add_row("slli",   i_type(OPI, 1, 18, 1, 12'h01c), 68, 18, 32'h50000000, 72, 0);
        add_row("srli",   i_type(OPI, 5, 19, 2, 12'h01c), 72, 19, 32'hf,        76, 0);
        add_row("srai",   i_type(OPI, 5, 20, 2, 12'h401), 76, 20, 32'hfffffffe, 80, 0);
        add_row("x0_wr",  i_type(OPI, 0, 0, 1, 12'd7),    80, 0,  32'd0,        84, 0);
        add_row("lui",    u_type(7'h37, 21, 20'habcde),   84, 21, 32'habcde000, 88, 0);
        add_row("auipc",  u_type(7'h17, 22, 20'h00001),   88, 22, 32'h1058,     92, 0);
        // Branch rows inspect the register that their rd field bits name, which must not change
        add_row("beq_t",  b_type(0, 1, 1, 8),   92,  8,  32'd1,        100, 0);
        add_row("beq_n",  b_type(0, 1, 2, 8),   100, 8,  32'd1,        104, 0);
        add_row("bne_t",  b_type(1, 1, 2, 8),   104, 8,  32'd1,        112, 0);
        add_row("bne_n",  b_type(1, 1, 1, 8),   112, 8,  32'd1,        116, 0);
        add_row("blt_t",  b_type(4, 2, 1, 8),   116, 8,  32'd1,        124, 0);
        add_row("blt_n",  b_type(4, 1, 2, 8),   124, 8,  32'd1,        128, 0);
        add_row("bge_t",  b_type(5, 1, 2, 8),   128, 8,  32'd1,        136, 0);
        add_row("bge_n",  b_type(5, 2, 1, 8),   136, 8,  32'd1,        140, 0);
        add_row("bltu_t", b_type(6, 1, 2, 8),   140, 8,  32'd1,        148, 0);
        add_row("bltu_n", b_type(6, 2, 1, 8),   148, 8,  32'd1,        152, 0);
        add_row("bgeu_t", b_type(7, 2, 1, 12),  152, 12, 32'hffffffff, 164, 0);
        add_row("bgeu_n", b_type(7, 1, 2, 8),   164, 8,  32'd1,        168, 0);
        add_row("jal",    j_type(23, 16),       168, 23, 32'd172,     184, 0);
        // Target 5 + 16 = 21 with bit 0 cleared
        add_row("jalr",   i_type(JALR, 0, 24, 1, 12'h010), 184, 24, 32'd188, 20, 0);
        // Store word sw x10, 10(x1) whose rd field bits name x10, which must keep its value
        add_row("illegal", 32'h00a0a523, 20, 10, 32'ha0, 24, 1);
    endtask

    // Memory model that serves the table rows in order with a random latency
    initial begin : responder
        int lat;
        void'($urandom(32'hd3ef));
        wait (rst === 1'b0);
        for (int i = 0; i < ROWS; i++) begin
            do begin
                @(posedge clk);
                #1;
            end while (!imem_req);
            cur = prog[i];
            @(posedge clk);
            #1;
            // No register can change before the first retire
            if (i == 0) begin
                for (int s = 0; s < 32; s++) begin
                    reg_read_sel = s[4:0];
                    sweep_active = 1'b1;
                    @(posedge clk);
                    #1;
                end
                sweep_active = 1'b0;
            end
            reg_read_sel = prog[i].sel;
            lat = $urandom_range(5, 0);
            repeat (lat) begin
                @(posedge clk);
                #1;
            end
            imem_valid = 1'b1;
            imem_rdata = prog[i].instr;
            @(posedge clk);
            #1;
            imem_valid = 1'b0;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        imem_valid   = 1'b0;
        imem_rdata   = '0;
        reg_read_sel = '0;
        sweep_active = 1'b0;
        cur          = '0;
        load_program();
        repeat (8) @(posedge clk);
        #1;
        rst    = 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retire_count, ROWS);
        end
        $display("Summary: %0d errors, %0d of %0d retired, %0d registers swept",
                 error_count, retire_count, ROWS, sweep_count);
        if (done && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
logic/core_pkg.sv
logic/decoded_if.sv
logic/reg_clear_counter.sv
logic/core_control.sv
logic/instr_decode.sv
logic/alu.sv
logic/int_regfile.sv
logic/pc_unit.sv
logic/core.sv
verification/core_checker.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - files:
      - logic/core_pkg.sv
      - logic/decoded_if.sv
      - logic/reg_clear_counter.sv
      - logic/core_control.sv
      - logic/instr_decode.sv
      - logic/alu.sv
      - logic/int_regfile.sv
      - logic/pc_unit.sv
      - logic/core.sv
  - target: test
    files:
      - verification/core_checker.sv
      - verification/core_tb.sv
